// ==== game_pkg.sv ====
package game_pkg;

    // game phases, encoded in 3 bits
    typedef enum logic [2:0] {
        idle       = 3'd0,
        greet      = 3'd1,
        show       = 3'd2,
        wait_guess = 3'd3,
        judge      = 3'd4,
        win        = 3'd5
    } game_state_t;

    // number of levels in one game
    localparam int max_level = 3;

    // level number, 1 to max_level
    typedef logic [1:0] level_t;

    // widest guess, used at the last level
    localparam int target_width = 7;

    // active target bits per level, entry 0 unused
    localparam logic [target_width-1:0] level_mask [0:3] = '{
        7'h00,
        7'h1f,
        7'h3f,
        7'h7f
    };

    // miss counter stops here
    localparam logic [3:0] miss_max = 4'd9;

endpackage

// ==== display_pkg.sv ====
package display_pkg;

    // active low segments, bit order dp g f e d c b a
    localparam int seg_blank = 10;
    localparam logic [7:0] seg_code [0:10] = '{
        8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99,
        8'h92, 8'h82, 8'hf8, 8'h80, 8'h90,
        8'hff
    };

    // digit positions on the eight-digit display
    localparam int num_digits = 8;
    localparam logic [2:0] dig_level = 3'd0;
    localparam logic [2:0] dig_misses = 3'd1;

    // one column word of the dot matrix, bit set means dot lit
    typedef logic [7:0] matrix_row_t;

    // greeting, reads "HI"
    localparam matrix_row_t greet_pattern [0:7] = '{
        8'h00, 8'h97, 8'h92, 8'hf2, 8'h92, 8'h92, 8'h97, 8'h00
    };

    // smiling face for the win
    localparam matrix_row_t win_pattern [0:7] = '{
        8'h3c, 8'h42, 8'ha5, 8'h81, 8'ha5, 8'h99, 8'h42, 8'h3c
    };

    // countdown digits 0 to 3
    localparam matrix_row_t count_glyph [0:3][0:7] = '{
        '{8'h3c, 8'h66, 8'h6e, 8'h76, 8'h66, 8'h66, 8'h3c, 8'h00},
        '{8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7e, 8'h00},
        '{8'h3c, 8'h66, 8'h06, 8'h0c, 8'h30, 8'h60, 8'h7e, 8'h00},
        '{8'h3c, 8'h66, 8'h06, 8'h1c, 8'h06, 8'h66, 8'h3c, 8'h00}
    };

endpackage

// ==== random_lfsr.sv ====
`timescale 1ns/1ps

module random_lfsr #(
    parameter logic [15:0] seed = 16'hace1
) (
    input  logic       clk,
    input  logic       sw,
    output logic [6:0] rand_value
);

    // a zero seed would lock the register, fall back to 1
    localparam logic [15:0] start_value = (seed == 16'h0000) ? 16'h0001 : seed;

    // x^16 + x^14 + x^13 + x^11 + 1, maximal length
    localparam logic [15:0] taps = 16'hb400;

    logic [15:0] lfsr;

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
            lfsr <= start_value;
        else if (lfsr[0])
            lfsr <= {1'b0, lfsr[15:1]} ^ taps;
        else
            lfsr <= {1'b0, lfsr[15:1]};
    end

    assign rand_value = lfsr[6:0];

endmodule

// ==== round_regs.sv ====
`timescale 1ns/1ps

module round_regs import game_pkg::*; (
    input  logic                    clk,
    input  logic                    sw,
    input  logic                    load_target,
    input  logic                    level_up,
    input  logic                    level_reset,
    input  logic                    miss,
    input  logic [target_width-1:0] rand_value,
    input  logic [target_width-1:0] guess,
    output level_t                  level,
    output logic [target_width-1:0] target_shown,
    output logic [3:0]              misses,
    output logic                    match
);

    level_t                  level_next;
    logic [target_width-1:0] target;

    // the new target is masked with the level it will be played at
    always_comb
    begin
        level_next = level;
        if (level_reset)
            level_next = 2'd1;
        else if (level_up && level != level_t'(max_level))
            level_next = level + 2'd1;
    end

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            level  <= 2'd1;
            misses <= 4'd0;
        end
        else
        begin
            level <= level_next;
            if (level_reset)
                misses <= 4'd0;
            else if (miss && misses != miss_max)
                misses <= misses + 4'd1;
        end
    end

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
            target <= '0;
        else if (load_target)
            target <= rand_value & level_mask[level_next];
    end

    assign target_shown = target;

    // only bits active at this level count
    assign match = ((guess ^ target) & level_mask[level]) == '0;

endmodule

// ==== game_fsm.sv ====
`timescale 1ns/1ps

module game_fsm import game_pkg::*; (
    input  logic   clk,
    input  logic   sw,
    input  logic   enable,
    input  logic   start,
    input  logic   restart,
    input  logic   expired,
    input  logic   match,
    input  level_t level,
    output logic   load_target,
    output logic   level_up,
    output logic   level_reset,
    output logic   miss,
    output logic   count_run,
    output logic   greet_on,
    output logic   win_on
);

    game_state_t state;
    game_state_t state_next;

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
            state <= idle;
        else
            state <= state_next;
    end

    // next state and round strobes
    always_comb
    begin
        state_next  = state;
        load_target = 1'b0;
        level_up    = 1'b0;
        level_reset = 1'b0;
        miss        = 1'b0;
        if (!enable)
            state_next = idle;
        else
        begin
            case (state)
                idle:
                    state_next = greet;
                greet, show, wait_guess, win:
                begin
                    if (restart)
                    begin
                        // back to level 1 with a fresh target
                        state_next  = show;
                        load_target = 1'b1;
                        level_reset = 1'b1;
                    end
                    else if (state == show && expired)
                        state_next = wait_guess;
                    else if (state == wait_guess && start)
                        state_next = judge;
                end
                judge:
                begin
                    if (match && level == level_t'(max_level))
                        state_next = win;
                    else
                    begin
                        state_next  = show;
                        load_target = 1'b1;
                        level_up    = match;
                        miss        = !match;
                    end
                end
                default:
                    state_next = idle;
            endcase
        end
    end

    // a restart during show drops the run for one cycle so the countdown starts over
    assign count_run = (state == show) && !restart;
    assign greet_on  = (state == greet);
    assign win_on    = (state == win);

endmodule

// ==== countdown_matrix.sv ====
`timescale 1ns/1ps

module countdown_matrix import display_pkg::*; #(
    parameter int tick_cycles = 50_000_000,
    parameter int count_steps = 3,
    parameter int scan_div    = 50_000
) (
    input  logic       clk,
    input  logic       sw,
    input  logic       count_run,
    input  logic       greet_on,
    input  logic       win_on,
    output logic       expired,
    output logic [7:0] row,
    output logic [7:0] colg,
    output logic [7:0] colr
);

    localparam int tick_w = $clog2(tick_cycles + 1);
    localparam int step_w = $clog2(count_steps + 1);
    localparam int scan_w = $clog2(scan_div + 1);
    localparam logic [tick_w-1:0] tick_last = tick_w'(tick_cycles - 1);
    localparam logic [step_w-1:0] step_last = step_w'(count_steps - 1);
    localparam logic [step_w-1:0] step_end = step_w'(count_steps);
    localparam logic [scan_w-1:0] scan_last = scan_w'(scan_div - 1);

    logic [tick_w-1:0] tick_cnt;
    logic [step_w-1:0] step_cnt;
    logic [scan_w-1:0] scan_cnt;
    logic [2:0]        row_idx;
    logic [step_w-1:0] remaining;
    logic [1:0]        glyph_idx;

    // countdown, cleared whenever the show phase is not running
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            tick_cnt <= '0;
            step_cnt <= '0;
        end
        else if (!count_run)
        begin
            tick_cnt <= '0;
            step_cnt <= '0;
        end
        else if (step_cnt != step_end)
        begin
            if (tick_cnt == tick_last)
            begin
                tick_cnt <= '0;
                step_cnt <= step_cnt + 1'b1;
            end
            else
                tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // high in the last cycle of the last step, so show lasts steps * ticks
    assign expired = count_run &&
        ((step_cnt == step_end) || (step_cnt == step_last && tick_cnt == tick_last));

    assign remaining = step_end - step_cnt;
    assign glyph_idx = 2'(remaining);

    // row scanner
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            scan_cnt <= '0;
            row_idx  <= 3'd0;
        end
        else if (scan_cnt == scan_last)
        begin
            scan_cnt <= '0;
            row_idx  <= row_idx + 3'd1;
        end
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

    // columns are active low, green for greeting and countdown, red for the win
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            row  <= 8'h00;
            colg <= 8'hff;
            colr <= 8'hff;
        end
        else if (greet_on || count_run || win_on)
        begin
            row <= 8'h01 << row_idx;
            if (greet_on)
            begin
                colg <= ~greet_pattern[row_idx];
                colr <= 8'hff;
            end
            else if (count_run)
            begin
                colg <= ~count_glyph[glyph_idx][row_idx];
                colr <= 8'hff;
            end
            else
            begin
                colg <= 8'hff;
                colr <= ~win_pattern[row_idx];
            end
        end
        else
        begin
            row  <= 8'h00;
            colg <= 8'hff;
            colr <= 8'hff;
        end
    end

endmodule

// ==== beep_gen.sv ====
`timescale 1ns/1ps

module beep_gen #(
    parameter int beep_cycles = 25_000_000,
    parameter int tone_half   = 25_000
) (
    input  logic clk,
    input  logic sw,
    input  logic miss,
    output logic beep
);

    localparam int dur_w  = $clog2(beep_cycles + 1);
    localparam int tone_w = $clog2(tone_half + 1);
    localparam logic [dur_w-1:0]  dur_load  = dur_w'(beep_cycles);
    localparam logic [tone_w-1:0] tone_last = tone_w'(tone_half - 1);

    logic [dur_w-1:0]  dur_cnt;
    logic [tone_w-1:0] tone_cnt;

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            dur_cnt  <= '0;
            tone_cnt <= '0;
            beep     <= 1'b0;
        end
        else if (miss)
        begin
            // a new miss restarts the tone
            dur_cnt  <= dur_load;
            tone_cnt <= '0;
            beep     <= 1'b0;
        end
        else if (dur_cnt != '0)
        begin
            dur_cnt <= dur_cnt - 1'b1;
            if (tone_cnt == tone_last)
            begin
                tone_cnt <= '0;
                beep     <= ~beep;
            end
            else
                tone_cnt <= tone_cnt + 1'b1;
        end
        else
        begin
            tone_cnt <= '0;
            beep     <= 1'b0;
        end
    end

endmodule

// ==== seg_display.sv ====
`timescale 1ns/1ps

module seg_display import game_pkg::*, display_pkg::*; #(
    parameter int scan_div = 50_000
) (
    input  logic       clk,
    input  logic       sw,
    input  logic       enable,
    input  level_t     level,
    input  logic [3:0] misses,
    output logic [7:0] seg,
    output logic [7:0] dig
);

    localparam int scan_w = $clog2(scan_div + 1);
    localparam logic [scan_w-1:0] scan_last = scan_w'(scan_div - 1);
    localparam logic [2:0] dig_last = 3'(num_digits - 1);

    logic [scan_w-1:0] scan_cnt;
    logic [2:0]        dig_idx;
    logic [7:0]        code;

    // digit scan
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            scan_cnt <= '0;
            dig_idx  <= 3'd0;
        end
        else if (scan_cnt == scan_last)
        begin
            scan_cnt <= '0;
            dig_idx  <= (dig_idx == dig_last) ? 3'd0 : dig_idx + 3'd1;
        end
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

    always_comb
    begin
        case (dig_idx)
            dig_level:  code = seg_code[level];
            dig_misses: code = seg_code[misses];
            default:    code = seg_code[seg_blank];
        endcase
    end

    // select lines are active low, all off while disabled
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            seg <= 8'hff;
            dig <= 8'hff;
        end
        else
        begin
            seg <= code;
            dig <= enable ? ~(8'h01 << dig_idx) : 8'hff;
        end
    end

endmodule

// ==== memory_game_top.sv ====
`timescale 1ns/1ps

module memory_game_top import game_pkg::*; #(
    parameter int          tick_cycles = 50_000_000,
    parameter int          count_steps = 3,
    parameter int          beep_cycles = 25_000_000,
    parameter int          tone_half   = 25_000,
    parameter int          scan_div    = 50_000,
    parameter logic [15:0] lfsr_seed   = 16'hace1
) (
    input  logic                    clk,
    input  logic                    sw,
    input  logic                    enable,
    input  logic                    start,
    input  logic                    restart,
    input  logic [target_width-1:0] guess,
    output logic [15:0]             led,
    output logic [7:0]              seg,
    output logic [7:0]              dig,
    output logic [7:0]              row,
    output logic [7:0]              colg,
    output logic [7:0]              colr,
    output logic                    beep
);

    logic [target_width-1:0] rand_value;
    logic [target_width-1:0] target_shown;
    logic                    load_target;
    logic                    level_up;
    logic                    level_reset;
    logic                    miss;
    logic                    match;
    logic                    expired;
    logic                    count_run;
    logic                    greet_on;
    logic                    win_on;
    level_t                  level;
    logic [3:0]              misses;

    random_lfsr #(
        .seed(lfsr_seed)
    ) u_random_lfsr (
        .clk        (clk),
        .sw         (sw),
        .rand_value (rand_value)
    );

    round_regs u_round_regs (
        .clk          (clk),
        .sw           (sw),
        .load_target  (load_target),
        .level_up     (level_up),
        .level_reset  (level_reset),
        .miss         (miss),
        .rand_value   (rand_value),
        .guess        (guess),
        .level        (level),
        .target_shown (target_shown),
        .misses       (misses),
        .match        (match)
    );

    game_fsm u_game_fsm (
        .clk         (clk),
        .sw          (sw),
        .enable      (enable),
        .start       (start),
        .restart     (restart),
        .expired     (expired),
        .match       (match),
        .level       (level),
        .load_target (load_target),
        .level_up    (level_up),
        .level_reset (level_reset),
        .miss        (miss),
        .count_run   (count_run),
        .greet_on    (greet_on),
        .win_on      (win_on)
    );

    countdown_matrix #(
        .tick_cycles (tick_cycles),
        .count_steps (count_steps),
        .scan_div    (scan_div)
    ) u_countdown_matrix (
        .clk       (clk),
        .sw        (sw),
        .count_run (count_run),
        .greet_on  (greet_on),
        .win_on    (win_on),
        .expired   (expired),
        .row       (row),
        .colg      (colg),
        .colr      (colr)
    );

    beep_gen #(
        .beep_cycles (beep_cycles),
        .tone_half   (tone_half)
    ) u_beep_gen (
        .clk  (clk),
        .sw   (sw),
        .miss (miss),
        .beep (beep)
    );

    seg_display #(
        .scan_div (scan_div)
    ) u_seg_display (
        .clk    (clk),
        .sw     (sw),
        .enable (enable),
        .level  (level),
        .misses (misses),
        .seg    (seg),
        .dig    (dig)
    );

    // target only while the countdown runs, all lit on a win
    assign led = count_run ? {{(16 - target_width){1'b0}}, target_shown}
               : (win_on ? 16'hffff : 16'h0000);

endmodule

// ==== tb_memory_game.sv ====
`timescale 1ns/1ps

module tb_memory_game import game_pkg::*, display_pkg::*; ();

    localparam int tick_cycles = 8;
    localparam int count_steps = 3;
    localparam int beep_cycles = 40;
    localparam int tone_half   = 2;
    localparam int scan_div    = 2;
    localparam int show_cycles = tick_cycles * count_steps;
    localparam int cycle_limit = 4000;

    logic                    clk;
    logic                    sw;
    logic                    enable;
    logic                    start;
    logic                    restart;
    logic [target_width-1:0] guess;
    logic [15:0]             led;
    logic [7:0]              seg;
    logic [7:0]              dig;
    logic [7:0]              row;
    logic [7:0]              colg;
    logic [7:0]              colr;
    logic                    beep;

    int                      error_count;
    int                      errors_at_start;
    int                      tests_ok;
    int                      tests_bad;
    int                      cycle_count;
    int                      beep_toggles;
    int                      toggles_before;
    int                      miss_mark;
    int                      flip;
    logic                    beep_prev;
    logic [target_width-1:0] target;

    memory_game_top #(
        .tick_cycles (tick_cycles),
        .count_steps (count_steps),
        .beep_cycles (beep_cycles),
        .tone_half   (tone_half),
        .scan_div    (scan_div)
    ) u_dut (
        .clk     (clk),
        .sw      (sw),
        .enable  (enable),
        .start   (start),
        .restart (restart),
        .guess   (guess),
        .led     (led),
        .seg     (seg),
        .dig     (dig),
        .row     (row),
        .colg    (colg),
        .colr    (colr),
        .beep    (beep)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    function automatic void report_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        error_count++;
    endfunction

    function automatic void report_failure(input string msg);
        $display("failure at %0t ns: %s", $time, msg);
        error_count++;
    endfunction

    // cycle counter with hard stop
    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    // count beep edges
    always @(posedge clk)
    begin
        if (beep !== beep_prev)
            beep_toggles = beep_toggles + 1;
        beep_prev = beep;
    end

    // two cycles of enable low bring back the idle outputs
    idle_outputs_check: assert property (@(posedge clk) disable iff (sw)
        (!enable && !$past(enable)) |=> (led == 16'h0000 && dig == 8'hff && row == 8'h00))
        else report_error("outputs not back to idle after enable dropped");

    function automatic int decode_seg(input logic [7:0] code);
        int k;
        for (k = 0; k <= seg_blank; k++)
        begin
            if (seg_code[k] == code)
                return k;
        end
        return -1;
    endfunction

    function automatic int row_index(input logic [7:0] r);
        int k;
        for (k = 0; k < 8; k++)
        begin
            if (r == (8'h01 << k))
                return k;
        end
        return -1;
    endfunction

    function automatic logic [15:0] led_mask(input int lvl);
        return {{(16 - target_width){1'b0}}, level_mask[lvl]};
    endfunction

    task automatic pulse_restart();
        @(negedge clk);
        restart = 1'b1;
        @(negedge clk);
        restart = 1'b0;
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    // entered one half cycle after the first show edge
    task automatic watch_show(input int lvl, output logic [target_width-1:0] shown);
        logic [15:0] first;
        int          i;
        first = 16'h0000;
        for (i = 1; i < show_cycles; i++)
        begin
            @(negedge clk);
            if (i == 1)
                first = led;
            else
                assert (led == first)
                    else report_error($sformatf("led changed to %h during show", led));
            assert ((led & ~led_mask(lvl)) == 16'h0000)
                else report_error($sformatf("led %h too wide for level %0d", led, lvl));
            assert (row != 8'h00)
                else report_error("matrix dark during the countdown");
        end
        @(negedge clk);
        assert (led == 16'h0000)
            else report_error($sformatf("led %h not dark after the show phase", led));
        @(negedge clk);
        assert (row == 8'h00)
            else report_error("matrix still lit while waiting for a guess");
        shown = first[target_width-1:0];
    endtask

    task automatic read_digit(input logic [2:0] pos, output int value);
        int waited;
        waited = 0;
        @(negedge clk);
        while (dig != ~(8'h01 << pos) && waited < 64)
        begin
            @(negedge clk);
            waited++;
        end
        if (waited >= 64)
        begin
            report_failure($sformatf("digit %0d was never selected by the scan", pos));
            value = -1;
        end
        else
            value = decode_seg(seg);
    endtask

    task automatic check_digits(input int exp_level, input int exp_misses);
        int value;
        read_digit(dig_level, value);
        assert (value == exp_level)
            else report_error($sformatf("digit 0 shows %0d, expected %0d", value, exp_level));
        read_digit(dig_misses, value);
        assert (value == exp_misses)
            else report_error($sformatf("digit 1 shows %0d, expected %0d", value, exp_misses));
    endtask

    // greeting in green or win face in red, checked row by row
    task automatic check_matrix(input logic use_red);
        int n;
        int idx;
        int seen;
        seen = 0;
        for (n = 0; n < 20; n++)
        begin
            @(negedge clk);
            idx = row_index(row);
            if (idx >= 0)
            begin
                seen++;
                if (use_red)
                    assert (colr == ~win_pattern[idx] && colg == 8'hff && led == 16'hffff)
                        else report_error($sformatf("win row %0d shows %h", idx, colr));
                else
                    assert (colg == ~greet_pattern[idx] && colr == 8'hff)
                        else report_error($sformatf("greet row %0d shows %h", idx, colg));
            end
        end
        if (seen == 0)
            report_failure("the matrix never scanned a row");
    endtask

    task automatic test_begin();
        errors_at_start = error_count;
    endtask

    task automatic test_end(input string name);
        if (error_count == errors_at_start)
        begin
            tests_ok++;
            $display("test %s: ok", name);
        end
        else
        begin
            tests_bad++;
            $display("test %s: %0d errors", name, error_count - errors_at_start);
        end
    endtask

    initial
    begin
        sw = 1'b1;
        enable = 1'b0;
        start = 1'b0;
        restart = 1'b0;
        guess = '0;
        error_count = 0;
        errors_at_start = 0;
        tests_ok = 0;
        tests_bad = 0;
        cycle_count = 0;
        beep_toggles = 0;
        beep_prev = 1'b0;
        target = '0;
        void'($urandom(32'hdaa7));
        repeat (2) @(posedge clk);
        @(negedge clk);
        sw = 1'b0;

        test_begin();
        repeat (3) @(negedge clk);
        assert (led == 16'h0000) else report_error($sformatf("led %h in idle", led));
        assert (beep == 1'b0) else report_error("beep high in idle");
        assert (dig == 8'hff) else report_error($sformatf("dig %h in idle", dig));
        assert (row == 8'h00) else report_error($sformatf("row %h in idle", row));
        test_end("reset and idle");

        test_begin();
        enable = 1'b1;
        check_matrix(1'b0);
        pulse_restart();
        watch_show(1, target);
        check_digits(1, 0);
        test_end("greeting and start");

        test_begin();
        guess = target;
        pulse_start();
        @(negedge clk);
        assert ((led & ~led_mask(2)) == 16'h0000)
            else report_error($sformatf("led %h too wide after level up", led));
        watch_show(2, target);
        check_digits(2, 0);
        test_end("correct guess");

        test_begin();
        // corrupt one bit inside the level 2 mask
        flip = int'($urandom % 6);
        guess = target ^ (7'h01 << flip);
        toggles_before = beep_toggles;
        pulse_start();
        miss_mark = cycle_count;
        @(negedge clk);
        watch_show(2, target);
        if (beep_toggles <= toggles_before)
            report_failure("beep did not toggle after a wrong guess");
        check_digits(2, 1);
        while (cycle_count < miss_mark + beep_cycles + 6)
            @(negedge clk);
        repeat (8)
        begin
            @(negedge clk);
            assert (beep == 1'b0) else report_error("beep still sounding after its length");
        end
        test_end("wrong guess");

        test_begin();
        guess = target;
        pulse_start();
        @(negedge clk);
        watch_show(3, target);
        check_digits(3, 1);
        guess = target;
        pulse_start();
        @(negedge clk);
        assert (led == 16'hffff) else report_error($sformatf("led %h on a win", led));
        check_matrix(1'b1);
        pulse_restart();
        watch_show(1, target);
        check_digits(1, 0);
        test_end("win and restart");

        test_begin();
        guess = target;
        pulse_start();
        @(negedge clk);
        repeat (5) @(negedge clk);
        enable = 1'b0;
        repeat (2) @(negedge clk);
        assert (led == 16'h0000) else report_error($sformatf("led %h after disable", led));
        assert (beep == 1'b0) else report_error("beep high after disable");
        assert (dig == 8'hff) else report_error($sformatf("dig %h after disable", dig));
        assert (row == 8'h00) else report_error($sformatf("row %h after disable", row));
        repeat (4) @(negedge clk);
        test_end("enable drop");

        $display("summary: %0d tests ok, %0d tests with errors, %0d errors in total",
                 tests_ok, tests_bad, error_count);
        if (error_count == 0 && tests_bad == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== list.f ====
game_pkg.sv
display_pkg.sv
random_lfsr.sv
round_regs.sv
game_fsm.sv
countdown_matrix.sv
beep_gen.sv
seg_display.sv
memory_game_top.sv
tb_memory_game.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the memory game testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_memory_game -f list.f -o tb_memory_game > "$build_log" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
    cat "$build_log"
    echo "compile failed with status $status"
    exit 1
fi

./obj_dir/tb_memory_game > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the result
if grep -q "Test failed" "$sim_log"; then
    exit 1
fi
exit 0
